//--- project.f
+incdir+logic
logic/lc_cmd_pkg.sv
logic/mbus_msg_pkg.sv
logic/int_action_rom.sv
logic/lc_word_counter.sv
logic/lc_int_fsm.sv
logic/lc_rf.sv
logic/lc_mem.sv
logic/lc_int_top.sv
tests/tb_lc_int.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_lc_int -f project.f -o sim_lc_int

out=$(./obj_dir/sim_lc_int 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
	exit 0
else
	exit 1
fi

//--- tests/tb_lc_int.sv
// Random rounds of interrupt lines from a fixed LFSR seed; the table constants are restated here by hand
`default_nettype none
`include "lc_params.svh"

module tb_lc_int;
	timeunit 1ns;
	timeprecision 100ps;

	import lc_cmd_pkg::*;
	import mbus_msg_pkg::*;

	localparam int CLK_NS = 4;
	localparam int DRIVE_DLY = 1;				// Input skew after the rising edge
	localparam int ROUNDS = 40;
	localparam int ACT_CYCLES = 20;				// Budget for one served action
	localparam int WATCHDOG_NS = ROUNDS * `LC_INT_DEPTH * ACT_CYCLES * CLK_NS
		+ (`LC_MEM_DEPTH + 32) * CLK_NS;		// Rounds plus preload and reset
	localparam mbus_addr_t RF_DEST = 8'h41;		// Layer 4, RF write
	localparam mbus_addr_t MEM_DEST = 8'h43;	// Layer 4, memory write

	logic clk;
	logic reset;
	int_vec_t int_vector;
	logic mem_wr_en;
	mem_addr_t mem_wr_addr;
	lc_word_t mem_wr_data;
	logic tx_valid;
	mbus_msg_t tx_msg;
	logic wakeup;
	logic int_done;
	int_idx_t done_index;
	logic busy;

	logic [31:0] lfsr_state;
	rf_data_t rf_model [`LC_RF_DEPTH];		// Mirror of the DUT register file
	lc_word_t mem_model [`LC_MEM_DEPTH];	// Mirror of the preloaded memory
	mbus_msg_t exp_q [$];					// Messages in the order they must leave
	int done_q [$];							// Raised lines still to complete
	int wakes_exp;
	int wakes_seen;
	int round;								// Negative until the first round
	logic irq_seen;							// Set once the first line is raised

	lc_int_top u_dut
	(
		.clk(clk), .reset(reset),
		.int_vector(int_vector),
		.mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
		.tx_valid(tx_valid), .tx_msg(tx_msg),
		.wakeup(wakeup), .int_done(int_done), .done_index(done_index), .busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS/2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0);	// Galois form, taps 32 31 29 1
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic string action_name(input int idx);
		string grp;
		case (idx / 4)
			0: grp = "A";
			1: grp = "B";
			2: grp = "C";
			default: grp = "D";
		endcase
		return $sformatf("%s%0d", grp, idx % 4 + 1);
	endfunction

	function automatic string current_test();
		if (round < 0)
			return "reset";
		if (done_q.size() == 0)
			return $sformatf("round %0d end", round);
		return $sformatf("round %0d %s", round, action_name(done_q[0]));
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		assert (exp === act) else
			abort_run($sformatf("[FAIL] %s %s expected %h actual %h",
				current_test(), what, exp, act));
	endtask

	// Length plus one replies, location byte above the RF value
	task automatic model_rf_read(input int from, input int len_m1, input int loc);
		for (int i = 0; i <= len_m1; i++)
			exp_q.push_back('{dest: RF_DEST,
				data: {8'((loc + i) % 256), rf_model[(from + i) % `LC_RF_DEPTH]},
				last: (i == len_m1)});
	endtask

	task automatic model_rf_write(input int addr, input rf_data_t data);
		if (addr < 127)
			rf_model[addr] = data;	// Top entry and beyond stay put
	endtask

	// Header with location times four, then the words
	task automatic model_mem_read(input int len_m1, input int start, input int loc);
		exp_q.push_back('{dest: MEM_DEST, data: 32'(loc * 4), last: 1'b0});
		for (int i = 0; i <= len_m1; i++)
			exp_q.push_back('{dest: MEM_DEST,
				data: mem_model[(start + i) % `LC_MEM_DEPTH], last: (i == len_m1)});
	endtask

	task automatic model_action(input int idx);
		case (idx)
			0: model_rf_read(0, 0, 0);
			1: model_rf_read(1, 0, 1);
			2: model_rf_read(2, 4, 2);
			3: model_rf_read(126, 4, 7);		// Wraps through 127 to 2
			4: model_rf_write(0, 24'habcdef);
			5:
			begin
				model_rf_write(1, 24'h123456);
				model_rf_write(3, 24'h987654);
			end
			6:
			begin
				model_rf_write(2, 24'h123321);
				model_rf_write(4, 24'habccba);
				model_rf_write(6, 24'h090785);
			end
			7:
			begin
				model_rf_write(5, 24'h052986);
				model_rf_write(127, 24'h031783);
				model_rf_write(128, 24'h101614);
			end
			8: model_mem_read(0, 0, 1);
			9: model_mem_read(4, 1, 2);
			10: model_mem_read(0, 65538, 3);	// Word 2
			11: model_mem_read(9, 65533, 3);	// 1021 up to 6
			default: wakes_exp++;				// D1 only wakes
		endcase
	endtask

	task automatic take_message();
		mbus_msg_t m;
		assert (exp_q.size() > 0) else
			abort_run($sformatf("Message %h arrived with none expected in %s",
				tx_msg, current_test()));
		m = exp_q.pop_front();
		check_value("tx_msg", 64'(m), 64'(tx_msg));
	endtask

	task automatic take_done();
		assert (done_q.size() > 0) else
			abort_run($sformatf("int_done pulsed with no raised line left in round %0d", round));
		check_value("done_index", 64'(done_q[0]), 64'(done_index));
		done_q.delete(0);
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (!irq_seen)
				check_value("idle outputs", 64'd0, 64'({tx_valid, wakeup, int_done, busy}));
			if (tx_valid)
				take_message();
			if (wakeup)
			begin
				wakes_seen++;
				assert (done_q.size() > 0) else
					abort_run("wakeup pulsed with no raised line in service");
				check_value("wakeup line", 64'd12, 64'(done_q[0]));
			end
			if (int_done)
				take_done();
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run($sformatf("Watchdog expired after %0d ns with actions unfinished", WATCHDOG_NS));
	end

	initial
	begin
		int_vec_t mask;
		reset = 1'b1;
		int_vector = '0;
		mem_wr_en = 1'b0;
		mem_wr_addr = '0;
		mem_wr_data = '0;
		lfsr_state = 32'd28;
		irq_seen = 1'b0;
		round = -1;
		wakes_exp = 0;
		wakes_seen = 0;
		for (int i = 0; i < `LC_RF_DEPTH; i++)
			rf_model[i] = '0;					// RF clears on reset
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;
		for (int a = 0; a < `LC_MEM_DEPTH; a++)
		begin
			mem_wr_en = 1'b1;
			mem_wr_addr = mem_addr_t'(a);
			mem_wr_data = take_bits(32);
			mem_model[a] = mem_wr_data;
			@(posedge clk);
			#DRIVE_DLY;
		end
		mem_wr_en = 1'b0;
		repeat (8) @(posedge clk);				// Quiet stretch before the first line
		#DRIVE_DLY;
		for (int r = 0; r < ROUNDS; r++)
		begin
			mask = (r == 0) ? '1 : int_vec_t'(take_bits(`LC_INT_DEPTH));	// First round raises all
			while (mask == '0)
				mask = int_vec_t'(take_bits(`LC_INT_DEPTH));
			round = r;
			wakes_exp = 0;
			wakes_seen = 0;
			for (int i = 0; i < `LC_INT_DEPTH; i++)
			begin
				if (mask[i])
				begin
					model_action(i);				// Lowest index served first
					done_q.push_back(i);
				end
			end
			int_vector = mask;
			irq_seen = 1'b1;
			@(posedge clk);
			#DRIVE_DLY;
			int_vector = '0;
			wait (busy);
			wait (!busy);
			@(negedge clk);
			check_value("messages left", 64'd0, 64'(exp_q.size()));
			check_value("lines left", 64'd0, 64'(done_q.size()));
			check_value("wakeup count", 64'(wakes_exp), 64'(wakes_seen));
			@(posedge clk);
			#DRIVE_DLY;
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/lc_int_top.sv
// Interrupt action engine top; outbound messages are strobes and the consumer is always ready
`default_nettype none
`include "lc_params.svh"

module lc_int_top
(
	input wire clk,
	input wire reset,
	input wire lc_cmd_pkg::int_vec_t int_vector,	// Rising level raises a line
	input wire mem_wr_en,
	input wire lc_cmd_pkg::mem_addr_t mem_wr_addr,
	input wire lc_cmd_pkg::lc_word_t mem_wr_data,
	output logic tx_valid,
	output mbus_msg_pkg::mbus_msg_t tx_msg,
	output logic wakeup,
	output logic int_done,
	output lc_cmd_pkg::int_idx_t done_index,
	output logic busy
);
	import lc_cmd_pkg::*;

	logic [`LC_FUNC_WIDTH*`LC_INT_DEPTH-1:0] int_func_id;
	logic [3*`LC_DATA_WIDTH*`LC_INT_DEPTH-1:0] int_payload;
	logic [2*`LC_INT_DEPTH-1:0] int_cmd_len;
	logic cnt_load, cnt_step, cnt_last;
	lc_len_t cnt_len, cnt_offset;
	rf_addr_t rf_rd_addr, rf_wr_addr;
	rf_data_t rf_wr_data, rf_rdata;
	logic rf_wr_en;
	mem_addr_t mem_rd_addr;
	lc_word_t mem_rdata;

	int_action_rom u_rom
	(
		.int_func_id(int_func_id),
		.int_payload(int_payload),
		.int_cmd_len(int_cmd_len)
	);

	lc_int_fsm u_fsm
	(
		.clk(clk), .reset(reset),
		.int_vector(int_vector),
		.int_func_id(int_func_id), .int_payload(int_payload), .int_cmd_len(int_cmd_len),
		.cnt_offset(cnt_offset), .cnt_last(cnt_last),
		.rf_rdata(rf_rdata), .mem_rdata(mem_rdata),
		.cnt_load(cnt_load), .cnt_len(cnt_len), .cnt_step(cnt_step),
		.rf_rd_addr(rf_rd_addr),
		.rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data),
		.mem_rd_addr(mem_rd_addr),
		.tx_valid(tx_valid), .tx_msg(tx_msg),
		.wakeup(wakeup), .int_done(int_done), .done_index(done_index), .busy(busy)
	);

	lc_word_counter u_cnt
	(
		.clk(clk), .reset(reset),
		.load(cnt_load), .len(cnt_len), .step(cnt_step),
		.offset(cnt_offset), .last(cnt_last)
	);

	lc_rf u_rf
	(
		.clk(clk), .reset(reset),
		.rd_addr(rf_rd_addr),
		.wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data),
		.rdata(rf_rdata)
	);

	lc_mem u_mem
	(
		.clk(clk),
		.wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
		.rd_addr(mem_rd_addr),
		.rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- logic/lc_mem.sv
// Local word memory; contents are undefined until preloaded, addresses wrap at the depth
`default_nettype none
`include "lc_params.svh"

module lc_mem
(
	input wire clk,
	input wire wr_en,								// Preload strobe
	input wire lc_cmd_pkg::mem_addr_t wr_addr,
	input wire lc_cmd_pkg::lc_word_t wr_data,
	input wire lc_cmd_pkg::mem_addr_t rd_addr,
	output lc_cmd_pkg::lc_word_t rdata				// One cycle after rd_addr
);
	import lc_cmd_pkg::*;

	localparam int AW = $clog2(`LC_MEM_DEPTH);

	lc_word_t mem_q [`LC_MEM_DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem_q[wr_addr[AW-1:0]] <= wr_data;	// High bits ignored
	end

	always_ff @(posedge clk)
	begin
		rdata <= mem_q[rd_addr[AW-1:0]];
	end

endmodule

`default_nettype wire

//--- logic/lc_rf.sv
// Local register file; top entry is read-only and addresses of 128 and up are never written
`default_nettype none
`include "lc_params.svh"

module lc_rf
(
	input wire clk,
	input wire reset,
	input wire lc_cmd_pkg::rf_addr_t rd_addr,		// Taken modulo the depth
	input wire wr_en,
	input wire lc_cmd_pkg::rf_addr_t wr_addr,
	input wire lc_cmd_pkg::rf_data_t wr_data,
	output lc_cmd_pkg::rf_data_t rdata				// One cycle after rd_addr
);
	import lc_cmd_pkg::*;

	localparam int AW = $clog2(`LC_RF_DEPTH);
	localparam int RF_TOP = `LC_RF_DEPTH - 1;

	rf_data_t regs [`LC_RF_DEPTH];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `LC_RF_DEPTH; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_addr < `LC_RF_WR_LIMIT))	// Drops 127 and out of range
			regs[wr_addr[AW-1:0]] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		rdata <= regs[rd_addr[AW-1:0]];
	end

	// Holds for any write pattern from the controller
	a_top_entry_fixed: assert property (@(posedge clk) disable iff (reset)
		$stable(regs[RF_TOP]));

endmodule

`default_nettype wire

//--- logic/lc_int_fsm.sv
// Interrupt controller; lowest pending line first, one read in flight behind each issued address
`default_nettype none
`include "lc_params.svh"

module lc_int_fsm
(
	input wire clk,
	input wire reset,
	input wire lc_cmd_pkg::int_vec_t int_vector,
	input wire [`LC_FUNC_WIDTH*`LC_INT_DEPTH-1:0] int_func_id,
	input wire [3*`LC_DATA_WIDTH*`LC_INT_DEPTH-1:0] int_payload,
	input wire [2*`LC_INT_DEPTH-1:0] int_cmd_len,
	input wire lc_cmd_pkg::lc_len_t cnt_offset,
	input wire cnt_last,
	input wire lc_cmd_pkg::rf_data_t rf_rdata,
	input wire lc_cmd_pkg::lc_word_t mem_rdata,
	output logic cnt_load,
	output lc_cmd_pkg::lc_len_t cnt_len,
	output logic cnt_step,
	output lc_cmd_pkg::rf_addr_t rf_rd_addr,
	output logic rf_wr_en,
	output lc_cmd_pkg::rf_addr_t rf_wr_addr,
	output lc_cmd_pkg::rf_data_t rf_wr_data,
	output lc_cmd_pkg::mem_addr_t mem_rd_addr,
	output logic tx_valid,
	output mbus_msg_pkg::mbus_msg_t tx_msg,
	output logic wakeup,
	output logic int_done,
	output lc_cmd_pkg::int_idx_t done_index,
	output logic busy
);
	import lc_cmd_pkg::*;
	import mbus_msg_pkg::*;

	localparam int PAY_W = 3*`LC_DATA_WIDTH;

	lc_state_e state, state_nx;
	int_vec_t int_prev, pending, pick_clr;
	int_idx_t pick_idx, cur_idx;
	lc_action_t act;
	lc_word_t w0, w1, w2, wr_word;
	logic issue, rd_issue;
	logic rd_vld_d, last_d;		// Read data valid this cycle, and its last flag
	lc_len_t off_d;				// Word offset of the returning data

	// Lowest pending line wins
	always_comb
	begin
		pick_idx = '0;
		for (int i = `LC_INT_DEPTH-1; i >= 0; i--)
			if (pending[i])
				pick_idx = int_idx_t'(i);
	end

	assign pick_clr = (state == PICK) ? (int_vec_t'(1) << pick_idx) : '0;

	// Entry of the line being served
	always_comb
	begin
		act.func = lc_func_e'(int_func_id[cur_idx*`LC_FUNC_WIDTH +: `LC_FUNC_WIDTH]);
		act.cmd_len = int_cmd_len[cur_idx*2 +: 2];
		act.payload = int_payload[cur_idx*PAY_W +: PAY_W];
	end

	assign w0 = act.payload[0];
	assign w1 = act.payload[1];
	assign w2 = act.payload[2];
	assign wr_word = act.payload[cnt_offset[1:0]];	// One RF write per word

	always_comb
	begin
		state_nx = state;
		case (state)
			IDLE: if (|pending) state_nx = PICK;
			PICK: state_nx = DECODE;
			DECODE:
			begin
				if (act.cmd_len == '0)
					state_nx = DONE;	// Wake-up only
				else
				begin
					case (act.func)
						RF_READ: state_nx = RF_RD;
						RF_WRITE: state_nx = RF_WR;
						MEM_READ: state_nx = MEM_HDR;
						default: state_nx = DONE;	// Nothing to do locally
					endcase
				end
			end
			RF_RD, RF_WR, MEM_RD: if (cnt_last) state_nx = DONE;
			MEM_HDR: state_nx = cnt_last ? DONE : MEM_RD;
			DONE: state_nx = (|pending) ? PICK : IDLE;	// Stay busy across queued lines
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			int_prev <= '0;
			pending <= '0;
			cur_idx <= '0;
			rd_vld_d <= 1'b0;
		end
		else
		begin
			state <= state_nx;
			int_prev <= int_vector;
			pending <= (pending & ~pick_clr) | (int_vector & ~int_prev);	// New edge wins
			if (state == PICK)
				cur_idx <= pick_idx;
			rd_vld_d <= rd_issue;
		end
	end

	always_ff @(posedge clk)
	begin
		off_d <= cnt_offset;	// Follows the one cycle read latency
		last_d <= cnt_last;
	end

	assign rd_issue = (state == RF_RD) || (state == MEM_HDR) || (state == MEM_RD);
	assign issue = rd_issue || (state == RF_WR);

	// Counter control
	assign cnt_load = (state == DECODE);
	assign cnt_step = issue && !cnt_last;
	always_comb
	begin
		case (act.func)
			RF_READ: cnt_len = lc_len_t'(w0[23:16]);
			RF_WRITE: cnt_len = lc_len_t'(act.cmd_len - 2'd1);
			MEM_READ: cnt_len = w0[19:0];
			default: cnt_len = '0;
		endcase
	end

	// Local storage ports
	assign rf_rd_addr = w0[31:24] + rf_addr_t'(cnt_offset);	// RF wraps it
	assign mem_rd_addr = mem_addr_t'(w1[31:2]) + mem_addr_t'(cnt_offset);	// Memory wraps it
	assign rf_wr_en = (state == RF_WR);
	assign rf_wr_addr = wr_word[31:24];
	assign rf_wr_data = wr_word[23:0];

	// Outbound message, header first for memory reads
	assign tx_valid = (state == MEM_HDR) || rd_vld_d;
	always_comb
	begin
		tx_msg = '0;
		if (state == MEM_HDR)
		begin
			tx_msg.dest = mbus_addr_t'(w0[31:24]);
			tx_msg.data = {w2[31:2], 2'b00};		// Reply location times four
		end
		else if (act.func == RF_READ)
		begin
			tx_msg.dest = mbus_addr_t'(w0[15:8]);
			tx_msg.data = {w0[7:0] + off_d[7:0], rf_rdata};	// Location byte above value
			tx_msg.last = last_d;
		end
		else
		begin
			tx_msg.dest = mbus_addr_t'(w0[31:24]);
			tx_msg.data = mem_rdata;
			tx_msg.last = last_d;
		end
	end

	assign wakeup = (state == DECODE) && (act.cmd_len == '0);
	assign int_done = (state == DONE);
	assign done_index = cur_idx;
	assign busy = (state != IDLE);

	a_tx_in_action: assert property (@(posedge clk) disable iff (reset) tx_valid |-> busy);
	a_wake_no_msg: assert property (@(posedge clk) disable iff (reset) !(wakeup && tx_valid));
	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(state));

endmodule

`default_nettype wire

//--- logic/lc_word_counter.sv
// Word counter for one action; len is the word count minus one, so last is high on the final word
`default_nettype none

module lc_word_counter
(
	input wire clk,
	input wire reset,
	input wire load,							// Start of an action
	input wire lc_cmd_pkg::lc_len_t len,		// Words minus one
	input wire step,							// Move to the next word
	output lc_cmd_pkg::lc_len_t offset,			// Index of the current word
	output logic last
);
	import lc_cmd_pkg::*;

	lc_len_t remain;	// Words left after the current one

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			remain <= '0;
			offset <= '0;
		end
		else if (load)
		begin
			remain <= len;
			offset <= '0;
		end
		else if (step)
		begin
			remain <= remain - 1'b1;
			offset <= offset + 1'b1;
		end
	end

	assign last = (remain == '0);

	// The controller leaves its issue state on the last word instead of stepping
	a_no_step_past_last: assert property (@(posedge clk) disable iff (reset)
		step |-> !last);

endmodule

`default_nettype wire

//--- logic/int_action_rom.sv
// Fixed interrupt table for groups A to D; any change here must be mirrored in the testbench model
`default_nettype none
`include "lc_params.svh"

module int_action_rom
(
	output logic [`LC_FUNC_WIDTH*`LC_INT_DEPTH-1:0] int_func_id,	// Entry i at slice i
	output logic [3*`LC_DATA_WIDTH*`LC_INT_DEPTH-1:0] int_payload,	// 96 bits per entry
	output logic [2*`LC_INT_DEPTH-1:0] int_cmd_len
);
	import lc_cmd_pkg::*;
	import mbus_msg_pkg::*;

	localparam int PAY_W = 3*`LC_DATA_WIDTH;
	localparam lc_word_t NO_WORD = '0;
	localparam mbus_addr_t RF_REPLY = '{short_addr: 4'd4, func: RF_WRITE};		// 0x41
	localparam mbus_addr_t MEM_REPLY = '{short_addr: 4'd4, func: MEM_WRITE};	// 0x43

	lc_action_t act [`LC_INT_DEPTH];

	// Start, length minus one, reply destination, reply location
	function automatic lc_word_t rf_rd_word(rf_addr_t from, rf_addr_t len_m1,
		mbus_addr_t dest, rf_addr_t loc);
		return {from, len_m1, dest, loc};
	endfunction

	function automatic lc_word_t rf_wr_word(rf_addr_t addr, rf_data_t data);
		return {addr, data};	// Address byte above the value
	endfunction

	// Reply header word, start word, reply location word
	function automatic lc_payload_t mem_rd_words(mbus_addr_t dest, lc_len_t len_m1,
		mem_addr_t start, mem_addr_t loc);
		return {dest, 4'b0000, len_m1, start, 2'b00, loc, 2'b00};
	endfunction

	// Group A, RF reads sent on to layer 4 as RF writes
	assign act[0] = '{func: RF_READ, cmd_len: 2'd1,
		payload: {rf_rd_word(8'd0, 8'd0, RF_REPLY, 8'd0), NO_WORD, NO_WORD}};
	assign act[1] = '{func: RF_READ, cmd_len: 2'd2,
		payload: {rf_rd_word(8'd1, 8'd0, RF_REPLY, 8'd1), NO_WORD, NO_WORD}};	// Word 1 unused
	assign act[2] = '{func: RF_READ, cmd_len: 2'd1,
		payload: {rf_rd_word(8'd2, 8'd4, RF_REPLY, 8'd2), NO_WORD, NO_WORD}};
	assign act[3] = '{func: RF_READ, cmd_len: 2'd1,
		payload: {rf_rd_word(8'd126, 8'd4, RF_REPLY, 8'd7), NO_WORD, NO_WORD}};	// Wraps past 127

	// Group B, local RF writes
	assign act[4] = '{func: RF_WRITE, cmd_len: 2'd1,
		payload: {rf_wr_word(8'd0, 24'habcdef), NO_WORD, NO_WORD}};
	assign act[5] = '{func: RF_WRITE, cmd_len: 2'd2,
		payload: {rf_wr_word(8'd1, 24'h123456), rf_wr_word(8'd3, 24'h987654), NO_WORD}};
	assign act[6] = '{func: RF_WRITE, cmd_len: 2'd3,
		payload: {rf_wr_word(8'd2, 24'h123321), rf_wr_word(8'd4, 24'habccba),
		rf_wr_word(8'd6, 24'h090785)}};
	assign act[7] = '{func: RF_WRITE, cmd_len: 2'd3,
		payload: {rf_wr_word(8'd5, 24'h052986), rf_wr_word(8'd127, 24'h031783),
		rf_wr_word(8'd128, 24'h101614)}};	// Last two must be dropped

	// Group C, memory reads sent on to layer 4 as memory writes
	assign act[8] = '{func: MEM_READ, cmd_len: 2'd3,
		payload: mem_rd_words(MEM_REPLY, 20'd0, 30'd0, 30'd1)};
	assign act[9] = '{func: MEM_READ, cmd_len: 2'd3,
		payload: mem_rd_words(MEM_REPLY, 20'd4, 30'd1, 30'd2)};
	assign act[10] = '{func: MEM_READ, cmd_len: 2'd3,
		payload: mem_rd_words(MEM_REPLY, 20'd0, 30'd65538, 30'd3)};	// Lands on word 2
	assign act[11] = '{func: MEM_READ, cmd_len: 2'd3,
		payload: mem_rd_words(MEM_REPLY, 20'd9, 30'd65533, 30'd3)};	// Crosses the top

	// Group D, wake-up only, function is a don't care
	assign act[12] = '{func: lc_func_e'(0), cmd_len: 2'd0, payload: '0};

	genvar i;
	generate
		for (i = 0; i < `LC_INT_DEPTH; i++)
		begin : g_pack
			assign int_func_id[i*`LC_FUNC_WIDTH +: `LC_FUNC_WIDTH] = act[i].func;
			assign int_payload[i*PAY_W +: PAY_W] = act[i].payload;
			assign int_cmd_len[i*2 +: 2] = act[i].cmd_len;
		end
	endgenerate

endmodule

`default_nettype wire

//--- logic/mbus_msg_pkg.sv
// Outbound bus message types; framing and arbitration live outside this engine
`default_nettype none
`include "lc_params.svh"

package mbus_msg_pkg;

	typedef logic [3:0] mbus_short_t;					// Short address of a layer
	typedef logic [3:0] mbus_func_t;					// Function nibble at that layer
	typedef logic [`LC_DATA_WIDTH-1:0] mbus_data_t;		// One data word on the bus

	typedef struct packed
	{
		mbus_short_t short_addr;
		mbus_func_t  func;
	} mbus_addr_t;

	// One message word, last marks the end of a transfer
	typedef struct packed
	{
		mbus_addr_t dest;
		mbus_data_t data;
		logic       last;
	} mbus_msg_t;

endpackage

`default_nettype wire

//--- logic/lc_cmd_pkg.sv
// Command side types of the layer controller; function code values follow the bus layer encoding
`default_nettype none
`include "lc_params.svh"

package lc_cmd_pkg;

	typedef logic [`LC_DATA_WIDTH-1:0] lc_word_t;		// One payload word
	typedef lc_word_t [0:2] lc_payload_t;				// Word 0 sits in the top bits
	typedef logic [7:0] rf_addr_t;						// RF address, upper bit may overflow
	typedef logic [23:0] rf_data_t;						// RF entry value
	typedef logic [29:0] mem_addr_t;					// Memory word address
	typedef logic [1:0] cmd_len_t;						// Payload words used, 0 is wake-up
	typedef logic [19:0] lc_len_t;						// Word count and word offset
	typedef logic [`LC_INT_DEPTH-1:0] int_vec_t;		// One bit per interrupt line
	typedef logic [$clog2(`LC_INT_DEPTH)-1:0] int_idx_t;	// Index of one line

	// Function codes as carried in the low nibble of a bus address
	typedef enum logic [`LC_FUNC_WIDTH-1:0]
	{
		RF_WRITE  = 4'h1,
		RF_READ   = 4'h2,
		MEM_WRITE = 4'h3,
		MEM_READ  = 4'h4
	} lc_func_e;

	typedef struct packed
	{
		lc_func_e    func;		// What to run
		cmd_len_t    cmd_len;	// Words of payload in use
		lc_payload_t payload;	// Raw command words
	} lc_action_t;

	typedef enum logic [2:0]
	{
		IDLE, PICK, DECODE, RF_RD, RF_WR, MEM_HDR, MEM_RD, DONE
	} lc_state_e;

endpackage

`default_nettype wire

//--- logic/lc_params.svh
// Engine sizes; RF and memory depths must stay powers of two so that addresses wrap by slicing
`ifndef LC_PARAMS_SVH
`define LC_PARAMS_SVH

// Number of interrupt lines and table entries
`define LC_INT_DEPTH 13

// One payload word
`define LC_DATA_WIDTH 32

// Function code of a table entry
`define LC_FUNC_WIDTH 4

// Local register file, 24-bit entries
`define LC_RF_DEPTH 128

// Writes at or above this address are dropped
`define LC_RF_WR_LIMIT 127

// Local memory in 32-bit words
`define LC_MEM_DEPTH 1024

`endif
